// ==== src.f ====
logic/dataMemPkg.sv
logic/memPortAdapter.sv
logic/memArbiter.sv
logic/dataMemBank.sv
logic/dataMemTop.sv
testbench/dataMemTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = dataMemTb
FILELIST  = src.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJDIR)

// ==== testbench/dataMemTb.sv ====
// testbench driving table-based port traffic into the shared data memory against a byte shadow
`timescale 1ns/1ns

module dataMemTb;
    import dataMemPkg::*;

    localparam logic [31:0] BASE_ADDR    = 32'h0000_2000;
    localparam int          DEPTH_WORDS  = 256;
    localparam int          WINDOW_BYTES = DEPTH_WORDS * 4;

    typedef struct packed {
        logic        port;
        memOp_t      op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expRdata;
        logic        expErr;
        logic        pair;
    } entry_t;

    logic       clk;
    logic       reset;
    logic [1:0] reqValid;
    logic [1:0] reqReady;
    memReq_t    req [2];
    logic [1:0] rspValid;
    logic [1:0] rspReady;
    memRsp_t    rsp [2];

    entry_t     entries[$];
    string      names[$];
    logic [7:0] shadow [WINDOW_BYTES];
    int         errors = 0;
    int         cycles = 0;
    int         limit = 0;

    dataMemTop #(
        .DEPTH_WORDS(DEPTH_WORDS),
        .BASE_ADDR  (BASE_ADDR),
        .NUM_PORTS  (2)
    ) i_dataMemTop (
        .clk     (clk),
        .reset   (reset),
        .reqValid(reqValid),
        .reqReady(reqReady),
        .req     (req),
        .rspValid(rspValid),
        .rspReady(rspReady),
        .rsp     (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: a request got no response within %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
            errors++;
        end
    endtask

    // reset leaves every byte of the window at zero
    task automatic clearShadow();
        for (int b = 0; b < WINDOW_BYTES; b++) begin
            shadow[b] = 8'h00;
        end
    endtask

    // reference behavior on a byte-wide shadow with little-endian lanes
    task automatic expectFor(input memOp_t op, input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        int          size;
        int          off;
        logic [31:0] val;
        case (op)
            LW, SW:       size = 4;
            LH, LHU, SH:  size = 2;
            default:      size = 1;
        endcase
        err = (addr < BASE_ADDR) || (addr >= BASE_ADDR + 32'(WINDOW_BYTES)) ||
              ((addr % 32'(size)) != 0);
        rdata = 32'h0;
        if (!err) begin
            off = int'(addr - BASE_ADDR);
            val = 32'h0;
            for (int b = 0; b < size; b++) begin
                if (op inside {SW, SH, SB}) shadow[off + b] = wdata[8*b +: 8];
                else val[8*b +: 8] = shadow[off + b];
            end
            // sign fill above the loaded width
            if (op inside {LH, LB} && val[8*size-1]) begin
                for (int b = 8 * size; b < 32; b++) val[b] = 1'b1;
            end
            if (!(op inside {SW, SH, SB})) rdata = val;
        end
    endtask

    task automatic addEntry(input string name, input int port, input memOp_t op,
                            input logic [31:0] addr, input logic [31:0] wdata, input logic pair);
        entry_t e;
        e.port  = port[0];
        e.op    = op;
        e.addr  = addr;
        e.wdata = wdata;
        e.pair  = pair;
        expectFor(op, addr, wdata, e.expRdata, e.expErr);
        entries.push_back(e);
        names.push_back(name);
    endtask

    task automatic buildTable();
        int          pick;
        int          k;
        int          lane;
        memOp_t      op;
        logic [31:0] addr;
        clearShadow();
        // memory clear
        addEntry("clear lw low", 0, LW, 32'h2000, 32'h0, 1'b0);
        addEntry("clear lw mid", 1, LW, 32'h2180, 32'h0, 1'b0);
        addEntry("clear lw top", 0, LW, 32'h23FC, 32'h0, 1'b0);
        // word store and load back across both ports
        addEntry("sw p0", 0, SW, 32'h2010, 32'hCAFE_F00D, 1'b0);
        addEntry("lw p0", 0, LW, 32'h2010, 32'h0, 1'b0);
        addEntry("sw p1", 1, SW, 32'h2020, 32'h1234_5678, 1'b0);
        addEntry("lw p1", 1, LW, 32'h2020, 32'h0, 1'b0);
        addEntry("lw cross", 0, LW, 32'h2020, 32'h0, 1'b0);
        // partial stores merge into one word
        addEntry("merge sw", 1, SW, 32'h2030, 32'h1122_3344, 1'b0);
        addEntry("merge sh", 0, SH, 32'h2032, 32'h0000_BEEF, 1'b0);
        addEntry("merge sb", 1, SB, 32'h2031, 32'h0000_00A5, 1'b0);
        addEntry("merge lw", 0, LW, 32'h2030, 32'h0, 1'b0);
        // sign and zero extension with the top bit clear and set
        addEntry("ext sw", 0, SW, 32'h2040, 32'h80FF_7F01, 1'b0);
        addEntry("lh pos", 1, LH, 32'h2040, 32'h0, 1'b0);
        addEntry("lh neg", 0, LH, 32'h2042, 32'h0, 1'b0);
        addEntry("lhu neg", 1, LHU, 32'h2042, 32'h0, 1'b0);
        addEntry("lb pos", 0, LB, 32'h2040, 32'h0, 1'b0);
        addEntry("lb neg", 1, LB, 32'h2042, 32'h0, 1'b0);
        addEntry("lbu neg", 0, LBU, 32'h2042, 32'h0, 1'b0);
        addEntry("lb neg hi", 1, LB, 32'h2043, 32'h0, 1'b0);
        addEntry("lbu hi", 0, LBU, 32'h2043, 32'h0, 1'b0);
        // rejected requests leave the memory unchanged
        addEntry("err below", 0, SW, 32'h1FFC, 32'hDEAD_BEEF, 1'b0);
        addEntry("err past end", 1, SW, 32'h2400, 32'hDEAD_BEEF, 1'b0);
        addEntry("err lw mis", 0, LW, 32'h2041, 32'h0, 1'b0);
        addEntry("err sw mis", 1, SW, 32'h2012, 32'hDEAD_BEEF, 1'b0);
        addEntry("err lh mis", 0, LH, 32'h2043, 32'h0, 1'b0);
        addEntry("err sh mis", 1, SH, 32'h2011, 32'h0000_FFFF, 1'b0);
        addEntry("after err low", 0, LW, 32'h2000, 32'h0, 1'b0);
        addEntry("after err top", 1, LW, 32'h23FC, 32'h0, 1'b0);
        addEntry("after err word", 0, LW, 32'h2010, 32'h0, 1'b0);
        // both ports at once with port 0 below 0x2200 and port 1 above
        for (int n = 0; n < 12; n++) begin
            for (int p = 0; p < 2; p++) begin
                pick = $urandom % 3;
                k    = $urandom % 64;
                lane = $urandom % 4;
                addr = 32'h2100 + 32'(p * 256 + k * 4);
                case (pick)
                    0:       op = SW;
                    1:       begin op = SH; addr = addr + 32'(lane & 2); end
                    default: begin op = SB; addr = addr + 32'(lane); end
                endcase
                addEntry($sformatf("pair %0d port %0d", n, p), p, op, addr, $urandom, 1'b1);
            end
        end
        for (int w = 0; w < 128; w++) begin
            addEntry($sformatf("readback %0d", w), w % 2, LW, 32'h2100 + 32'(w * 4), 32'h0, 1'b0);
        end
    endtask

    task automatic runEntry(input int idx);
        entry_t      e;
        int          p;
        logic        got;
        logic [31:0] data;
        logic        err;
        e   = entries[idx];
        p   = int'(e.port);
        got = 1'b0;
        @(negedge clk);
        req[p].op    = e.op;
        req[p].addr  = e.addr;
        req[p].wdata = e.wdata;
        reqValid[p]  = 1'b1;
        while (!reqReady[p]) @(negedge clk);
        @(negedge clk);
        reqValid[p] = 1'b0;
        // random stalls on the response side
        while (!got) begin
            rspReady[p] = ($urandom % 3) != 0;
            if (rspValid[p] && rspReady[p]) begin
                got  = 1'b1;
                data = rsp[p].rdata;
                err  = rsp[p].err;
            end
            @(negedge clk);
        end
        rspReady[p] = 1'b0;
        checkValue(names[idx], e.expRdata, data);
        checkValue({names[idx], " err"}, 32'(e.expErr), 32'(err));
        checkValue({names[idx], " one response"}, 32'h0, 32'(rspValid[p]));
    endtask

    initial begin
        int i;
        int first;
        void'($urandom(16));
        reset    = 1'b1;
        reqValid = 2'b00;
        rspReady = 2'b00;
        req[0]   = '0;
        req[1]   = '0;
        buildTable();
        limit = 64 * entries.size() + 2000;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        checkValue("reset reqReady", 32'h3, 32'(reqReady));
        checkValue("reset rspValid", 32'h0, 32'(rspValid));
        i = 0;
        while (i < entries.size()) begin
            if (entries[i].pair && i + 1 < entries.size()) begin
                fork
                    runEntry(i);
                    runEntry(i + 1);
                join
                i = i + 2;
            end else begin
                runEntry(i);
                i = i + 1;
            end
        end
        // a second reset must clear words that now hold data
        reset = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        clearShadow();
        first = entries.size();
        addEntry("reset again word", 0, LW, 32'h2010, 32'h0, 1'b0);
        addEntry("reset again merge", 1, LW, 32'h2030, 32'h0, 1'b0);
        addEntry("reset again ext", 0, LW, 32'h2040, 32'h0, 1'b0);
        limit = 64 * entries.size() + 2000;
        for (int n = first; n < entries.size(); n++) begin
            runEntry(n);
        end
        repeat (4) @(negedge clk);
        $display("errors: %0d over %0d table entries", errors, entries.size());
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/dataMemTop.sv ====
// shared data memory built from per-port adapters, a round-robin arbiter and one memory bank
`timescale 1ns/1ns

module dataMemTop #(
    parameter int          DEPTH_WORDS = 256,
    parameter logic [31:0] BASE_ADDR   = 32'h0000_2000,
    parameter int          NUM_PORTS   = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] reqValid,
    output logic [NUM_PORTS-1:0] reqReady,
    input  dataMemPkg::memReq_t  req [NUM_PORTS],
    output logic [NUM_PORTS-1:0] rspValid,
    input  logic [NUM_PORTS-1:0] rspReady,
    output dataMemPkg::memRsp_t  rsp [NUM_PORTS]
);
    import dataMemPkg::*;

    logic [NUM_PORTS-1:0] bankValid;
    bankReq_t             bankReq [NUM_PORTS];
    logic [NUM_PORTS-1:0] bankGrant;
    logic [31:0]          bankRdata;
    logic                 memValid;
    bankReq_t             memReq;
    logic [31:0]          memRdata;

    // one adapter per host port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : portGen
        memPortAdapter #(
            .DEPTH_WORDS(DEPTH_WORDS),
            .BASE_ADDR  (BASE_ADDR)
        ) i_memPortAdapter (
            .clk      (clk),
            .reset    (reset),
            .reqValid (reqValid[p]),
            .reqReady (reqReady[p]),
            .req      (req[p]),
            .rspValid (rspValid[p]),
            .rspReady (rspReady[p]),
            .rsp      (rsp[p]),
            .bankValid(bankValid[p]),
            .bankReq  (bankReq[p]),
            .bankGrant(bankGrant[p]),
            .bankRdata(bankRdata)
        );
    end

    memArbiter #(
        .NUM_PORTS(NUM_PORTS)
    ) i_memArbiter (
        .clk      (clk),
        .reset    (reset),
        .bankValid(bankValid),
        .bankReq  (bankReq),
        .bankGrant(bankGrant),
        .memValid (memValid),
        .memReq   (memReq),
        .memRdata (memRdata),
        .bankRdata(bankRdata)
    );

    dataMemBank #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) i_dataMemBank (
        .clk     (clk),
        .reset   (reset),
        .memValid(memValid),
        .memReq  (memReq),
        .memRdata(memRdata)
    );

endmodule

// ==== logic/dataMemBank.sv ====
// single-ported data memory with byte-enabled writes, registered reads and sweeping clear
`timescale 1ns/1ns

module dataMemBank #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 memValid,
    input  dataMemPkg::bankReq_t memReq,
    output logic [31:0]          memRdata
);
    import dataMemPkg::*;

    localparam int ADDR_W      = $clog2(DEPTH_WORDS);
    // words cleared per reset cycle
    localparam int CLEAR_WORDS = 16;
    localparam int ROWS        = DEPTH_WORDS / CLEAR_WORDS;
    localparam int ROW_W       = (ROWS > 1) ? $clog2(ROWS) : 1;

    logic [31:0]       mem [DEPTH_WORDS];
    logic [ADDR_W-1:0] wordAddr;
    // wrapping row counter covers the whole array within ROWS reset cycles from any start
    logic [ROW_W-1:0]  clearRow = '0;

    assign wordAddr = memReq.wordIndex[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < CLEAR_WORDS; w++) begin
                mem[int'(clearRow) * CLEAR_WORDS + w] <= 32'h0;
            end
            clearRow <= (clearRow == ROW_W'(ROWS - 1)) ? '0 : clearRow + 1'b1;
        end else if (memValid) begin
            if (memReq.write) begin
                // only enabled lanes change
                for (int b = 0; b < 4; b++) begin
                    if (memReq.byteEn[b]) begin
                        mem[wordAddr][8*b +: 8] <= memReq.wdata[8*b +: 8];
                    end
                end
            end else begin
                memRdata <= mem[wordAddr];
            end
        end
    end

    // adapters filter out-of-window addresses before arbitration
    indexInRange: assert property (@(posedge clk) disable iff (reset)
        memValid |-> (32'(memReq.wordIndex) < 32'(DEPTH_WORDS)))
        else $error("bank access beyond memory depth");

endmodule

// ==== logic/memArbiter.sv ====
// round-robin arbiter sharing one memory bank between port adapters
`timescale 1ns/1ns

module memArbiter #(
    parameter int NUM_PORTS = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NUM_PORTS-1:0]  bankValid,
    input  dataMemPkg::bankReq_t  bankReq [NUM_PORTS],
    output logic [NUM_PORTS-1:0]  bankGrant,
    output logic                  memValid,
    output dataMemPkg::bankReq_t  memReq,
    input  logic [31:0]           memRdata,
    output logic [31:0]           bankRdata
);
    import dataMemPkg::*;

    localparam int IDX_W = $clog2(NUM_PORTS);

    logic [IDX_W-1:0] lastGrant;
    logic [IDX_W-1:0] winner;
    logic             found;

    // search starts one past the last winner
    always_comb begin
        int cand;
        bankGrant = '0;
        winner    = lastGrant;
        found     = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = (int'(lastGrant) + i) % NUM_PORTS;
            if (!found && bankValid[cand]) begin
                found           = 1'b1;
                winner          = IDX_W'(cand);
                bankGrant[cand] = 1'b1;
            end
        end
    end

    // grant history
    always_ff @(posedge clk) begin
        if (reset) begin
            lastGrant <= IDX_W'(NUM_PORTS - 1);
        end else if (found) begin
            lastGrant <= winner;
        end
    end

    assign memValid = found;
    assign memReq   = bankReq[winner];

    // read data goes to every adapter; only the last grantee takes it
    assign bankRdata = memRdata;

    grantOneHot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(bankGrant) && ((bankGrant & ~bankValid) == '0))
        else $error("grant not one-hot or given to an idle requester");

endmodule

// ==== logic/memPortAdapter.sv ====
// host port adapter turning loads and stores into byte-enabled bank requests and shaping load data
`timescale 1ns/1ns

module memPortAdapter #(
    parameter int          DEPTH_WORDS = 256,
    parameter logic [31:0] BASE_ADDR   = 32'h0000_2000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reqValid,
    output logic                 reqReady,
    input  dataMemPkg::memReq_t  req,
    output logic                 rspValid,
    input  logic                 rspReady,
    output dataMemPkg::memRsp_t  rsp,
    output logic                 bankValid,
    output dataMemPkg::bankReq_t bankReq,
    input  logic                 bankGrant,
    input  logic [31:0]          bankRdata
);
    import dataMemPkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_GRANT, WAIT_DATA, RESPOND} state_t;

    state_t      state;
    accessSize_t reqSize;
    logic        reqSigned;
    logic        reqWrite;
    logic [31:0] offset;
    logic        inWindow;
    logic        aligned;
    logic        reqErr;
    logic [3:0]  laneMask;
    logic [31:0] laneData;
    accessSize_t pendSize;
    logic        pendSigned;
    logic        pendWrite;
    logic        pendErr;
    logic [1:0]  pendOffset;
    logic [31:0] shiftedRdata;
    logic [31:0] loadData;

    // opcode decode
    always_comb begin
        reqSize   = WORD;
        reqSigned = 1'b0;
        reqWrite  = 1'b0;
        case (req.op)
            LH:      begin reqSize = HALF; reqSigned = 1'b1; end
            LHU:     reqSize = HALF;
            LB:      begin reqSize = BYTE; reqSigned = 1'b1; end
            LBU:     reqSize = BYTE;
            SW:      reqWrite = 1'b1;
            SH:      begin reqSize = HALF; reqWrite = 1'b1; end
            SB:      begin reqSize = BYTE; reqWrite = 1'b1; end
            default: reqSize = WORD;
        endcase
    end

    // below-base addresses wrap to a large offset and fail the window check
    assign offset   = req.addr - BASE_ADDR;
    assign inWindow = offset < 32'(DEPTH_WORDS * 4);
    assign aligned  = (reqSize == BYTE) ||
                      (reqSize == HALF && !offset[0]) ||
                      (reqSize == WORD && offset[1:0] == 2'b00);
    assign reqErr   = !inWindow || !aligned;

    // little-endian lane steering
    always_comb begin
        case (reqSize)
            HALF: begin
                laneMask = 4'b0011 << offset[1:0];
                laneData = {16'h0, req.wdata[15:0]} << {offset[1:0], 3'b000};
            end
            BYTE: begin
                laneMask = 4'b0001 << offset[1:0];
                laneData = {24'h0, req.wdata[7:0]} << {offset[1:0], 3'b000};
            end
            default: begin
                laneMask = 4'b1111;
                laneData = req.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                // an error skips the bank but keeps one cycle for the response
                IDLE:       if (reqValid) state <= reqErr ? WAIT_DATA : WAIT_GRANT;
                WAIT_GRANT: if (bankGrant) state <= WAIT_DATA;
                WAIT_DATA:  state <= RESPOND;
                RESPOND:    if (rspReady) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    // request and pending-load record
    always_ff @(posedge clk) begin
        if (state == IDLE && reqValid) begin
            bankReq.wordIndex <= offset[17:2];
            bankReq.byteEn    <= laneMask;
            bankReq.write     <= reqWrite;
            bankReq.wdata     <= laneData;
            pendSize          <= reqSize;
            pendSigned        <= reqSigned;
            pendWrite         <= reqWrite;
            pendErr           <= reqErr;
            pendOffset        <= offset[1:0];
        end
        if (state == WAIT_DATA) begin
            rsp.rdata <= (pendErr || pendWrite) ? 32'h0 : loadData;
            rsp.err   <= pendErr;
        end
    end

    // load extraction with sign or zero extension
    assign shiftedRdata = bankRdata >> {pendOffset, 3'b000};
    always_comb begin
        case (pendSize)
            HALF:    loadData = {{16{pendSigned & shiftedRdata[15]}}, shiftedRdata[15:0]};
            BYTE:    loadData = {{24{pendSigned & shiftedRdata[7]}}, shiftedRdata[7:0]};
            default: loadData = bankRdata;
        endcase
    end

    assign reqReady  = (state == IDLE);
    assign bankValid = (state == WAIT_GRANT);
    assign rspValid  = (state == RESPOND);

    // request must hold until the arbiter takes it
    holdUntilGrant: assert property (@(posedge clk) disable iff (reset)
        bankValid && !bankGrant |=> bankValid && $stable(bankReq))
        else $error("bank request dropped or changed before grant");

endmodule

// ==== logic/dataMemPkg.sv ====
// data memory package with opcodes, access sizes and request/response structs
package dataMemPkg;

    // MIPS-style host memory operations
    typedef enum logic [3:0] {
        LW  = 4'h0,
        LH  = 4'h1,
        LHU = 4'h2,
        LB  = 4'h3,
        LBU = 4'h4,
        SW  = 4'h5,
        SH  = 4'h6,
        SB  = 4'h7
    } memOp_t;

    // access width of one operation
    typedef enum logic [1:0] {
        WORD = 2'd0,
        HALF = 2'd1,
        BYTE = 2'd2
    } accessSize_t;

    // 68-bit host request
    typedef struct packed {
        memOp_t      op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } memReq_t;

    // 33-bit host response
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } memRsp_t;

    // 53-bit word-wide request from adapter through arbiter to the bank
    // wdata is already steered into its byte lanes
    typedef struct packed {
        logic [15:0] wordIndex;
        logic [3:0]  byteEn;
        logic        write;
        logic [31:0] wdata;
    } bankReq_t;

endpackage
